//--- bit_buf_pkg.sv
package bit_buf_pkg;

	//////////////////////////////////////////////////
	// buffer geometry
	//////////////////////////////////////////////////

	// width of one pushed stream word
	localparam int WORD_W = 32;

	// one stream word, bit 0 is the first bit in stream order
	typedef logic [WORD_W-1:0] word_t;

	// depth is not fixed here
	// each block takes it as a parameter and sizes its own pointers
	// so the buffer can be any power of two in words

endpackage

//--- bit_field_pkg.sv
package bit_field_pkg;

	//////////////////////////////////////////////////
	// field requests and results
	//////////////////////////////////////////////////

	// longest field a consumer may ask for
	// also the width of the read window
	localparam int FIELD_MAX = 15;

	// requested length, 0 to FIELD_MAX
	typedef logic [3:0] field_len_t;

	// extracted field, zero-extended above its length
	typedef logic [FIELD_MAX-1:0] field_t;

	// a length of 0 is legal and returns all zeros

endpackage

//--- word_store.sv
`timescale 1ns/1ps

module word_store
	import bit_buf_pkg::*;
	import bit_field_pkg::*;
#(
	parameter int BUF_WORDS = 32,
	localparam int PTR_W = $clog2(BUF_WORDS),
	localparam int ADDR_W = $clog2(BUF_WORDS * WORD_W)
) (
	input logic clk,
	input logic rst,
	input logic pushin,
	input word_t datain,
	input logic [ADDR_W-1:0] rd_addr,
	output field_t window
);

	// bit offset inside one word
	localparam int OFF_W = $clog2(WORD_W);

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	// words 0 .. BUF_WORDS-1 hold the ring
	// word BUF_WORDS is a copy of word 0
	// a window starting in the top word runs into the copy
	word_t mem [0:BUF_WORDS];

	// next word to be written, wraps on its own
	logic [PTR_W-1:0] wr_ptr;

	// read side
	logic [PTR_W-1:0] lo_idx;
	logic [PTR_W:0] hi_idx;
	logic [OFF_W-1:0] bit_off;
	logic [2*WORD_W-1:0] pair;
	logic [2*WORD_W-1:0] shifted;

	//////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (pushin) begin
			// one step per pushed word
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pushin) begin
			mem[wr_ptr] <= datain;
			// word 0 also lands in the mirror slot
			if (wr_ptr == '0) begin
				mem[BUF_WORDS] <= datain;
			end
		end
	end

	//////////////////////////////////////////////////
	// read window
	//////////////////////////////////////////////////

	// split the bit address into word index and offset
	assign bit_off = rd_addr[OFF_W-1:0];
	assign lo_idx = rd_addr[ADDR_W-1:OFF_W];

	// top word pairs with the mirror, never with word 0 itself
	assign hi_idx = {1'b0, lo_idx} + 1'b1;

	// two adjacent words cover any 15 bit field
	// offset at most 31, so the field ends by bit 45
	assign pair = {mem[hi_idx], mem[lo_idx]};
	assign shifted = pair >> bit_off;

	// lsb of the window is the bit at rd_addr
	assign window = shifted[FIELD_MAX-1:0];

endmodule

//--- field_reader.sv
`timescale 1ns/1ps

module field_reader
	import bit_buf_pkg::*;
	import bit_field_pkg::*;
#(
	parameter int BUF_WORDS = 32,
	localparam int ADDR_W = $clog2(BUF_WORDS * WORD_W)
) (
	input logic clk,
	input logic rst,
	input logic reqin,
	input field_len_t reqlen,
	input field_t window,
	output logic [ADDR_W-1:0] rd_addr,
	output logic pushout,
	output field_len_t lenout,
	output field_t dataout
);

	//////////////////////////////////////////////////
	// internal signals
	//////////////////////////////////////////////////

	// bit address of the next unread bit
	// wraps modulo the buffer size in bits
	logic [ADDR_W-1:0] rd_ptr;

	// length mask, one bit wider to hold 1 << 15
	logic [FIELD_MAX:0] mask_full;
	field_t mask;
	field_t field;

	// stage one
	logic s1_valid;
	field_len_t s1_len;
	field_t s1_data;

	//////////////////////////////////////////////////
	// masking
	//////////////////////////////////////////////////

	// reqlen ones from the bottom
	// length 0 gives an empty mask, 15 gives all ones
	assign mask_full = ((FIELD_MAX + 1)'(1) << reqlen) - 1'b1;
	assign mask = mask_full[FIELD_MAX-1:0];

	// drop window bits above the requested length
	assign field = window & mask;

	// the store reads at the current pointer
	assign rd_addr = rd_ptr;

	//////////////////////////////////////////////////
	// stage one and read pointer
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			s1_valid <= 1'b0;
			s1_len <= '0;
			s1_data <= '0;
		end else begin
			s1_valid <= reqin;
			if (reqin) begin
				s1_len <= reqlen;
				s1_data <= field;
				// consume the field, power of two size wraps by itself
				rd_ptr <= rd_ptr + ADDR_W'(reqlen);
			end
			// no request, data and length stay put
		end
	end

	//////////////////////////////////////////////////
	// stage two, the outputs
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pushout <= 1'b0;
			lenout <= '0;
			dataout <= '0;
		end else begin
			pushout <= s1_valid;
			lenout <= s1_len;
			dataout <= s1_data;
		end
	end

	// a result only ever follows a request by two edges
	a_no_stray_push: assert property (
		@(posedge clk) disable iff (rst) !reqin |=> ##1 !pushout
	) else $error("pushout without a request two cycles earlier");

endmodule

//--- fill_tracker.sv
`timescale 1ns/1ps

module fill_tracker
	import bit_buf_pkg::*;
	import bit_field_pkg::*;
#(
	parameter int BUF_WORDS = 32,
	localparam int LVL_W = $clog2(BUF_WORDS * WORD_W + 1)
) (
	input logic clk,
	input logic rst,
	input logic pushin,
	input logic reqin,
	input field_len_t reqlen,
	output logic [LVL_W-1:0] level
);

	// total buffer size in bits
	localparam int CAP = BUF_WORDS * WORD_W;

	logic [LVL_W-1:0] add_bits;
	logic [LVL_W-1:0] sub_bits;

	//////////////////////////////////////////////////
	// level counter
	//////////////////////////////////////////////////

	// a push adds a whole word, a request removes its length
	assign add_bits = pushin ? LVL_W'(WORD_W) : '0;
	assign sub_bits = reqin ? LVL_W'(reqlen) : '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			level <= '0;
		end else begin
			// both strobes in one cycle net out
			level <= level + add_bits - sub_bits;
		end
	end

	//////////////////////////////////////////////////
	// producer and consumer rules
	//////////////////////////////////////////////////

	// a push must find room for a full word
	// else the write pointer laps unread bits
	a_no_overflow: assert property (
		@(posedge clk) disable iff (rst) pushin |-> level <= LVL_W'(CAP - WORD_W)
	) else $error("push with level %0d above capacity minus a word", level);

	// bits pushed this same cycle are not yet readable
	a_no_overread: assert property (
		@(posedge clk) disable iff (rst) reqin |-> LVL_W'(reqlen) <= level
	) else $error("request of %0d bits with only %0d buffered", reqlen, level);

endmodule

//--- bit_unpacker_top.sv
`timescale 1ns/1ps

module bit_unpacker_top
	import bit_buf_pkg::*;
	import bit_field_pkg::*;
#(
	parameter int BUF_WORDS = 32,
	localparam int ADDR_W = $clog2(BUF_WORDS * WORD_W),
	localparam int LVL_W = $clog2(BUF_WORDS * WORD_W + 1)
) (
	input logic clk,
	input logic rst,
	input logic pushin,
	input word_t datain,
	input logic reqin,
	input field_len_t reqlen,
	output logic pushout,
	output field_len_t lenout,
	output field_t dataout,
	output logic [LVL_W-1:0] level
);

	//////////////////////////////////////////////////
	// internal wiring
	//////////////////////////////////////////////////

	// reader pointer into the store
	logic [ADDR_W-1:0] rd_addr;

	// unmasked 15 bits at rd_addr
	field_t window;

	// ring of words with the mirrored word 0
	word_store #(
		.BUF_WORDS(BUF_WORDS)
	) store_i (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.datain(datain),
		.rd_addr(rd_addr),
		.window(window)
	);

	// pointer, mask and the two output stages
	field_reader #(
		.BUF_WORDS(BUF_WORDS)
	) reader_i (
		.clk(clk),
		.rst(rst),
		.reqin(reqin),
		.reqlen(reqlen),
		.window(window),
		.rd_addr(rd_addr),
		.pushout(pushout),
		.lenout(lenout),
		.dataout(dataout)
	);

	// bits available to consumers
	fill_tracker #(
		.BUF_WORDS(BUF_WORDS)
	) fill_i (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.reqin(reqin),
		.reqlen(reqlen),
		.level(level)
	);

endmodule

//--- tb_bit_unpacker.sv
`timescale 1ns/1ps

module tb_bit_unpacker
	import bit_buf_pkg::*;
	import bit_field_pkg::*;
;

	localparam int BUF_WORDS = 32;
	localparam int CAP = BUF_WORDS * WORD_W;
	localparam int LVL_W = $clog2(CAP + 1);

	// phase lengths in cycles
	localparam int P_FILL = 600;
	localparam int P_MIX = 1800;
	localparam int P_DRAIN = 600;
	localparam int RUN_CYCLES = P_FILL + P_MIX + P_DRAIN;
	// margin covers reset, pipeline drain and idle tail
	localparam int TIMEOUT = RUN_CYCLES + 500;

	logic clk;
	logic rst;
	logic pushin;
	word_t datain;
	logic reqin;
	field_len_t reqlen;
	logic pushout;
	field_len_t lenout;
	field_t dataout;
	logic [LVL_W-1:0] level;

	bit_unpacker_top #(
		.BUF_WORDS(BUF_WORDS)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.datain(datain),
		.reqin(reqin),
		.reqlen(reqlen),
		.pushout(pushout),
		.lenout(lenout),
		.dataout(dataout),
		.level(level)
	);

	//////////////////////////////////////////////////
	// clock, cycle count, timeout
	//////////////////////////////////////////////////

	int cycle = 0;

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	//////////////////////////////////////////////////
	// reference model state
	//////////////////////////////////////////////////

	// stream bits not yet requested, oldest first
	logic stream_q[$];
	// results in flight, due = cycle count when pushout should show them
	field_t exp_data[$];
	field_len_t exp_len[$];
	int exp_due[$];
	// outputs hold these between results
	field_t last_data = '0;
	field_len_t last_len = '0;
	logic [15:0] lfsr = 16'd82;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one lfsr step per bit taken
	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("error at %0t: %s", $time, why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_field(input string name, input field_t got, input field_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			fail_run("field value differs from model");
		end
	endtask

	task automatic check_len(input string name, input field_len_t got, input field_len_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			fail_run("field length differs from model");
		end
	endtask

	task automatic check_level(input string name, input logic [LVL_W-1:0] got,
			input logic [LVL_W-1:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			fail_run("fill level differs from model");
		end
	endtask

	// called on the falling edge, outputs are settled
	task automatic check_outputs();
		check_level("level", level, stream_q.size());
		if (exp_due.size() > 0 && exp_due[0] == cycle) begin
			if (pushout !== 1'b1)
				fail_run("pushout missing or late two cycles after reqin");
			last_data = exp_data.pop_front();
			last_len = exp_len.pop_front();
			void'(exp_due.pop_front());
		end else if (pushout !== 1'b0) begin
			fail_run("pushout high with no request two cycles earlier");
		end
		// result cycle or hold cycle, both compare against last_*
		check_field("dataout", dataout, last_data);
		check_len("lenout", lenout, last_len);
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// weights are out of 8
	task automatic drive_cycle(input int push_wt, input int req_wt);
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] l;
		int avail;
		field_t f;
		// only bits pushed before this cycle are readable
		avail = stream_q.size();
		pushin = 1'b0;
		reqin = 1'b0;
		reqlen = '0;
		draw(3, r);
		if (r < req_wt) begin
			draw(4, l);
			if (l > avail)
				l = avail;
			f = '0;
			// lsb first in stream order
			for (int i = 0; i < l; i++)
				f[i] = stream_q.pop_front();
			reqin = 1'b1;
			reqlen = l[3:0];
			exp_data.push_back(f);
			exp_len.push_back(l[3:0]);
			// sampled at the next edge, shown on the falling edge two cycles on
			exp_due.push_back(cycle + 2);
		end
		draw(3, r);
		// push needs room for a whole word
		if (r < push_wt && avail <= CAP - WORD_W) begin
			draw(32, w);
			datain = w;
			pushin = 1'b1;
			for (int i = 0; i < WORD_W; i++)
				stream_q.push_back(w[i]);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		pushin = 1'b0;
		datain = '0;
		reqin = 1'b0;
		reqlen = '0;
		// reset for two cycles, outputs must read zero
		repeat (2) begin
			@(negedge clk);
			check_outputs();
		end
		rst = 1'b0;
		// fill toward full, stays near capacity
		repeat (P_FILL) begin
			@(negedge clk);
			check_outputs();
			drive_cycle(7, 2);
		end
		// mixed traffic, many laps of the ring
		repeat (P_MIX) begin
			@(negedge clk);
			check_outputs();
			drive_cycle(2, 6);
		end
		// back to back requests, buffer drains
		repeat (P_DRAIN) begin
			@(negedge clk);
			check_outputs();
			drive_cycle(1, 8);
		end
		// idle until every result is out, then a short hold check
		while (exp_due.size() > 0) begin
			@(negedge clk);
			check_outputs();
			pushin = 1'b0;
			reqin = 1'b0;
		end
		repeat (4) begin
			@(negedge clk);
			check_outputs();
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- filelist.f
bit_buf_pkg.sv
bit_field_pkg.sv
word_store.sv
field_reader.sv
fill_tracker.sv
bit_unpacker_top.sv
tb_bit_unpacker.sv

//--- Bender.yml
package:
  name: bit_unpacker

dependencies: {}

sources:
  # packages first
  - bit_buf_pkg.sv
  - bit_field_pkg.sv
  # design blocks
  - word_store.sv
  - field_reader.sv
  - fill_tracker.sv
  - bit_unpacker_top.sv
  # testbench
  - target: test
    files:
      - tb_bit_unpacker.sv
